//--- hdl/audio_dac.sv
`timescale 1ns/1ps

module audio_dac #(
    parameter int AUDIO_W = 11
) (
    input  logic               clk_sys,
    input  logic               arst_n_i,
    input  logic [AUDIO_W-1:0] audio_i,
    input  logic               tape_in_i,
    input  logic               tape_on_i,
    output logic               audio_o
);

    localparam logic [AUDIO_W:0] FULL_SCALE = (AUDIO_W+1)'(2**AUDIO_W - 1);
    localparam logic [AUDIO_W:0] TAPE_LVL   = (AUDIO_W+1)'(2**(AUDIO_W-2));

    logic [AUDIO_W:0]   mix_sum;
    logic [AUDIO_W-1:0] mix;
    logic [AUDIO_W-1:0] acc_q;

    // Halve the core sample to leave headroom for the tape bit
    always_comb begin
        if (tape_on_i) begin
            mix_sum = {2'b00, audio_i[AUDIO_W-1:1]} + (tape_in_i ? TAPE_LVL : '0);
        end else begin
            mix_sum = {1'b0, audio_i};
        end
    end
    assign mix = mix_sum[AUDIO_W-1:0];

    // First order sigma-delta, the carry is the output bit
    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_q   <= '0;
            audio_o <= 1'b0;
        end else begin
            {audio_o, acc_q} <= {1'b0, acc_q} + {1'b0, mix};
        end
    end

    a_mix_range: assert property (
        @(posedge clk_sys) disable iff (!arst_n_i) mix_sum <= FULL_SCALE
    ) else $error("mixed sample above full scale");

endmodule

//--- hdl/clock_reset_ctrl.sv
`timescale 1ns/1ps

module clock_reset_ctrl #(
    parameter int RST_HOLD = 32
) (
    input  logic clk_sys,
    input  logic arst_n_i,
    input  logic pll_locked_i,
    input  logic ioctl_download_i,
    input  logic reset_req_i,
    input  logic mode_change_i,
    output logic ce_10m7_o,
    output logic ce_5m3_o,
    output logic core_rst_n_o
);

    localparam int HOLD_W = $clog2(RST_HOLD + 1);

    logic [2:0]        div_q;
    logic [HOLD_W-1:0] hold_q;
    logic              cause;

    // 42.7 MHz / 4 and / 8, both taken from one counter so they line up
    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_q     <= '0;
            ce_10m7_o <= 1'b0;
            ce_5m3_o  <= 1'b0;
        end else begin
            div_q     <= div_q + 3'd1;
            ce_10m7_o <= (div_q[1:0] == 2'd0);
            ce_5m3_o  <= (div_q == 3'd0);
        end
    end

    assign cause = !pll_locked_i || ioctl_download_i || reset_req_i || mode_change_i;

    // Hold counter reloads on every cause, reset released once it runs out
    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hold_q       <= HOLD_W'(RST_HOLD);
            core_rst_n_o <= 1'b0;
        end else begin
            if (cause) begin
                hold_q <= HOLD_W'(RST_HOLD);
            end else if (hold_q != '0) begin
                hold_q <= hold_q - 1'b1;
            end
            core_rst_n_o <= !cause && (hold_q == '0);
        end
    end

    a_ce_align: assert property (
        @(posedge clk_sys) disable iff (!arst_n_i) ce_5m3_o |-> ce_10m7_o
    ) else $error("ce_5m3 without ce_10m7");

    // Core stays in reset for the full hold time after a cause
    a_hold: assert property (
        @(posedge clk_sys) disable iff (!arst_n_i)
        cause |=> !core_rst_n_o [*RST_HOLD]
    ) else $error("core reset released early");

endmodule

//--- hdl/m5_shell_top.sv
`timescale 1ns/1ps

module m5_shell_top
    import shell_cfg_pkg::*, shell_io_pkg::*;
#(
    parameter int ROM_AW   = 14,
    parameter int AUDIO_W  = 11,
    parameter int RST_HOLD = 32
) (
    input  logic               clk_sys,
    input  logic               arst_n_i,
    input  logic               pll_locked_i,
    input  logic [31:0]        status_i,
    input  logic [JOY_W-1:0]   joy0_i,
    input  logic [JOY_W-1:0]   joy1_i,
    input  logic               ioctl_download_i,
    input  logic [7:0]         ioctl_index_i,
    input  logic               ioctl_wr_i,
    input  logic [24:0]        ioctl_addr_i,
    input  logic [BYTE_W-1:0]  ioctl_dout_i,
    input  logic [ROM_AW-1:0]  rom_rd_addr_i,
    input  logic [AUDIO_W-1:0] audio_i,
    input  logic               tape_in_i,
    output logic               ce_10m7_o,
    output logic               ce_5m3_o,
    output logic               core_rst_n_o,
    output mem_ext_t           mem_ext_o,
    output cart_t              cart_o,
    output logic [EM64_W-1:0]  em64_opts_o,
    output logic               cart_enable_o,
    output logic               kb64_enable_o,
    output logic               border_o,
    output logic [SCAN_W-1:0]  scanlines_o,
    output logic [JOY_W-1:0]   joy_a_o,
    output logic [JOY_W-1:0]   joy_b_o,
    output logic [BYTE_W-1:0]  rom_rd_data_o,
    output logic               rom_loaded_o,
    output logic               rom_overflow_o,
    output logic               audio_o
);

    logic mode_change;
    logic reset_req;
    logic load_enable;
    logic tape_on;

    shell_config i_shell_config (
        .clk_sys       (clk_sys),
        .arst_n_i      (arst_n_i),
        .status_i      (status_i),
        .joy0_i        (joy0_i),
        .joy1_i        (joy1_i),
        .mem_ext_o     (mem_ext_o),
        .cart_o        (cart_o),
        .em64_opts_o   (em64_opts_o),
        .cart_enable_o (cart_enable_o),
        .kb64_enable_o (kb64_enable_o),
        .border_o      (border_o),
        .scanlines_o   (scanlines_o),
        .joy_a_o       (joy_a_o),
        .joy_b_o       (joy_b_o),
        .mode_change_o (mode_change),
        .reset_req_o   (reset_req),
        .load_enable_o (load_enable),
        .tape_on_o     (tape_on)
    );

    clock_reset_ctrl #(.RST_HOLD(RST_HOLD)) i_clock_reset_ctrl (
        .clk_sys          (clk_sys),
        .arst_n_i         (arst_n_i),
        .pll_locked_i     (pll_locked_i),
        .ioctl_download_i (ioctl_download_i),
        .reset_req_i      (reset_req),
        .mode_change_i    (mode_change),
        .ce_10m7_o        (ce_10m7_o),
        .ce_5m3_o         (ce_5m3_o),
        .core_rst_n_o     (core_rst_n_o)
    );

    rom_loader #(.ROM_AW(ROM_AW)) i_rom_loader (
        .clk_sys          (clk_sys),
        .arst_n_i         (arst_n_i),
        .ioctl_download_i (ioctl_download_i),
        .ioctl_index_i    (ioctl_index_i),
        .ioctl_wr_i       (ioctl_wr_i),
        .ioctl_addr_i     (ioctl_addr_i),
        .ioctl_dout_i     (ioctl_dout_i),
        .load_enable_i    (load_enable),
        .rom_rd_addr_i    (rom_rd_addr_i),
        .rom_rd_data_o    (rom_rd_data_o),
        .rom_loaded_o     (rom_loaded_o),
        .rom_overflow_o   (rom_overflow_o)
    );

    audio_dac #(.AUDIO_W(AUDIO_W)) i_audio_dac (
        .clk_sys   (clk_sys),
        .arst_n_i  (arst_n_i),
        .audio_i   (audio_i),
        .tape_in_i (tape_in_i),
        .tape_on_i (tape_on),
        .audio_o   (audio_o)
    );

endmodule

//--- hdl/rom_loader.sv
`timescale 1ns/1ps

module rom_loader
    import shell_io_pkg::*;
#(
    parameter int ROM_AW = 14
) (
    input  logic              clk_sys,
    input  logic              arst_n_i,
    input  logic              ioctl_download_i,
    input  logic [7:0]        ioctl_index_i,
    input  logic              ioctl_wr_i,
    input  logic [24:0]       ioctl_addr_i,
    input  logic [BYTE_W-1:0] ioctl_dout_i,
    input  logic              load_enable_i,
    input  logic [ROM_AW-1:0] rom_rd_addr_i,
    output logic [BYTE_W-1:0] rom_rd_data_o,
    output logic              rom_loaded_o,
    output logic              rom_overflow_o
);

    logic [BYTE_W-1:0] rom_mem [0:2**ROM_AW-1];

    ld_state_t state_q;
    logic      dl_q;
    logic      dl_start;
    logic      is_binrom;
    logic      in_range;
    logic      wr_ok;
    logic      wr_en;
    logic      wrote_q;

    assign dl_start  = ioctl_download_i && !dl_q;
    assign is_binrom = (dl_target_t'(ioctl_index_i) == DL_BINROM);
    assign in_range  = (ioctl_addr_i[24:ROM_AW] == '0);
    assign wr_ok     = ioctl_wr_i && ioctl_download_i && is_binrom && load_enable_i;
    assign wr_en     = wr_ok && in_range;

    always_ff @(posedge clk_sys) begin
        if (wr_en) begin
            rom_mem[ioctl_addr_i[ROM_AW-1:0]] <= ioctl_dout_i;
        end
        rom_rd_data_o <= rom_mem[rom_rd_addr_i];
    end

    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q        <= LD_IDLE;
            dl_q           <= 1'b0;
            wrote_q        <= 1'b0;
            rom_overflow_o <= 1'b0;
        end else begin
            dl_q <= ioctl_download_i;
            if (dl_start) begin  // New download clears the sticky flags
                wrote_q        <= 1'b0;
                rom_overflow_o <= 1'b0;
            end
            if (wr_en) wrote_q <= 1'b1;
            if (wr_ok && !in_range) rom_overflow_o <= 1'b1;

            case (state_q)
                LD_LOADING: begin
                    if (!ioctl_download_i) state_q <= wrote_q ? LD_DONE : LD_IDLE;
                end
                default: begin  // Idle or done, wait for the next BINROM download
                    if (dl_start) state_q <= is_binrom ? LD_LOADING : LD_IDLE;
                end
            endcase
        end
    end

    assign rom_loaded_o = (state_q == LD_DONE);

    a_no_stale_load: assert property (
        @(posedge clk_sys) disable iff (!arst_n_i)
        (!ioctl_download_i && $past(!ioctl_download_i)) |-> (state_q != LD_LOADING)
    ) else $error("loader still loading after download ended");

endmodule

//--- hdl/shell_cfg_pkg.sv
package shell_cfg_pkg;

    // Memory extension selected in the OSD
    typedef enum logic [2:0] {
        MEM_NONE  = 3'd0,
        MEM_EM5   = 3'd1,
        MEM_EM64  = 3'd2,
        MEM_64KBF = 3'd3,
        MEM_64KRX = 3'd4,
        MEM_BRNO  = 3'd5
    } mem_ext_t;

    typedef enum logic [1:0] {
        CART_NONE    = 2'd0,
        CART_BASIC_I = 2'd1,
        CART_BASIC_G = 2'd2,
        CART_BASIC_F = 2'd3
    } cart_t;

    // Field positions in the status word
    localparam int ST_MEM_LSB  = 0;
    localparam int ST_CART_LSB = 3;
    localparam int ST_EM64_LSB = 5;
    localparam int ST_JOY_SWAP = 9;
    localparam int ST_TAPE_OFF = 10;  // Set means tape sound off
    localparam int ST_SCAN_LSB = 14;
    localparam int ST_BORDER   = 16;
    localparam int ST_RESET    = 17;

    localparam int EM64_W = 4;
    localparam int SCAN_W = 2;

    // Memory and cartridge bits, a change here restarts the core
    localparam int MODE_BITS = 5;

endpackage

//--- hdl/shell_config.sv
`timescale 1ns/1ps

module shell_config
    import shell_cfg_pkg::*, shell_io_pkg::*;
(
    input  logic              clk_sys,
    input  logic              arst_n_i,
    input  logic [31:0]       status_i,
    input  logic [JOY_W-1:0]  joy0_i,
    input  logic [JOY_W-1:0]  joy1_i,
    output mem_ext_t          mem_ext_o,
    output cart_t             cart_o,
    output logic [EM64_W-1:0] em64_opts_o,
    output logic              cart_enable_o,
    output logic              kb64_enable_o,
    output logic              border_o,
    output logic [SCAN_W-1:0] scanlines_o,
    output logic [JOY_W-1:0]  joy_a_o,
    output logic [JOY_W-1:0]  joy_b_o,
    output logic              mode_change_o,
    output logic              reset_req_o,
    output logic              load_enable_o,
    output logic              tape_on_o
);

    logic [ST_RESET:0]    status_q;
    logic [MODE_BITS-1:0] mode_prev_q;
    logic                 swap;

    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            status_q      <= '0;
            mode_prev_q   <= '0;
            mode_change_o <= 1'b0;
        end else begin
            status_q      <= status_i[ST_RESET:0];
            mode_prev_q   <= status_q[MODE_BITS-1:0];
            mode_change_o <= (status_q[MODE_BITS-1:0] != mode_prev_q);
        end
    end

    assign mem_ext_o   = mem_ext_t'(status_q[ST_MEM_LSB +: 3]);
    assign cart_o      = cart_t'(status_q[ST_CART_LSB +: 2]);
    assign em64_opts_o = status_q[ST_EM64_LSB +: EM64_W];
    assign scanlines_o = status_q[ST_SCAN_LSB +: SCAN_W];
    assign border_o    = status_q[ST_BORDER];
    assign reset_req_o = status_q[ST_RESET];
    assign tape_on_o   = !status_q[ST_TAPE_OFF];  // OSD bit is "tape off"

    // Cartridge slot only exists without the bigger RAM expansions
    assign cart_enable_o = (mem_ext_o == MEM_NONE) || (mem_ext_o == MEM_EM5)
                        || (mem_ext_o == MEM_EM64);
    assign load_enable_o = cart_enable_o && (cart_o == CART_NONE);
    assign kb64_enable_o = (mem_ext_o == MEM_EM64);

    assign swap    = status_q[ST_JOY_SWAP];
    assign joy_a_o = swap ? joy1_i : joy0_i;
    assign joy_b_o = swap ? joy0_i : joy1_i;

    a_mode_pulse: assert property (
        @(posedge clk_sys) disable iff (!arst_n_i) mode_change_o |=> !mode_change_o
    ) else $error("mode_change longer than one cycle");

endmodule

//--- hdl/shell_io_pkg.sv
package shell_io_pkg;

    localparam int JOY_W  = 6;
    localparam int BYTE_W = 8;

    // Download index from the file loader
    typedef enum logic [7:0] {
        DL_BOOT   = 8'd0,
        DL_BINROM = 8'd1
    } dl_target_t;

    // Progress of one ROM download
    typedef enum logic [1:0] {
        LD_IDLE,
        LD_LOADING,
        LD_DONE
    } ld_state_t;

endpackage

//--- list.f
hdl/shell_cfg_pkg.sv
hdl/shell_io_pkg.sv
hdl/clock_reset_ctrl.sv
hdl/shell_config.sv
hdl/rom_loader.sv
hdl/audio_dac.sv
hdl/m5_shell_top.sv
sim/tb_m5_shell.sv

//--- sim/tb_m5_shell.sv
`timescale 1ns/1ps

module tb_m5_shell
    import shell_cfg_pkg::*, shell_io_pkg::*;
();

    localparam int ROM_AW   = 14;
    localparam int AUDIO_W  = 11;
    localparam int RST_HOLD = 32;

    logic clk_sys = 1'b0;
    logic arst_n_i, pll_locked_i, ioctl_download_i, ioctl_wr_i, tape_in_i;
    logic [31:0] status_i;
    logic [JOY_W-1:0] joy0_i, joy1_i, joy_a_o, joy_b_o;
    logic [7:0] ioctl_index_i;
    logic [24:0] ioctl_addr_i;
    logic [BYTE_W-1:0] ioctl_dout_i, rom_rd_data_o;
    logic [ROM_AW-1:0] rom_rd_addr_i;
    logic [AUDIO_W-1:0] audio_i;
    logic ce_10m7_o, ce_5m3_o, core_rst_n_o, cart_enable_o, kb64_enable_o, border_o;
    logic rom_loaded_o, rom_overflow_o, audio_o;
    mem_ext_t mem_ext_o;
    cart_t cart_o;
    logic [EM64_W-1:0] em64_opts_o;
    logic [SCAN_W-1:0] scanlines_o;

    int errors = 0;
    int seed = 32'h717cc288;
    int quiet_cnt, ones_cnt, dens_exp;
    logic [31:0] status_d;
    logic [MODE_BITS-1:0] mode_prev;
    logic mode_pulse, cause, wr_bad;
    logic cnt_clr, cnt_en, dens_chk, rd_chk, expect_loaded;
    logic [BYTE_W-1:0] rd_exp;
    logic [BYTE_W-1:0] rom_model [0:2**ROM_AW-1];
    logic [ROM_AW-1:0] addr_q [$];

    m5_shell_top i_dut (.*);

    always #50 clk_sys = !clk_sys;

    // Returns {cart_enable, kb64_enable}
    function automatic logic [1:0] cfg_flags(logic [31:0] st);
        mem_ext_t mem;
        mem = mem_ext_t'(st[ST_MEM_LSB +: 3]);
        return {(mem == MEM_NONE || mem == MEM_EM5 || mem == MEM_EM64), (mem == MEM_EM64)};
    endfunction

    function automatic logic load_rule(logic [31:0] st);
        logic [1:0] f;
        f = cfg_flags(st);
        return f[1] && (st[ST_CART_LSB +: 2] == CART_NONE);
    endfunction

    function automatic int mixed_sample(int smp, logic tape_on, logic tape_hi);
        if (!tape_on) return smp;
        return (smp >> 1) + (tape_hi ? 2**(AUDIO_W-2) : 0);
    endfunction

    task automatic flag_mismatch(string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic report_test(string name);
        $display("%s finished, %0d errors so far", name, errors);
    endtask

    // Reset shows up a few cycles after its cause, so start looking a bit later
    task automatic wait_release(string what);
        int n;
        n = 0;
        repeat (4) @(posedge clk_sys);
        while (!core_rst_n_o && n < 200) begin
            @(posedge clk_sys);
            n++;
        end
        if (!core_rst_n_o) begin
            $display("Timeout waiting for core reset release after %s", what);
            errors++;
        end
        repeat (4) @(posedge clk_sys);
    endtask

    task automatic wait_loaded();
        int n;
        n = 0;
        while (!rom_loaded_o && n < 20) begin
            @(posedge clk_sys);
            n++;
        end
        if (!rom_loaded_o) begin
            $display("Timeout waiting for rom_loaded after ROM download");
            errors++;
        end
    endtask

    task automatic start_download(logic [7:0] idx);
        @(posedge clk_sys);
        ioctl_index_i    <= idx;
        ioctl_download_i <= 1'b1;
    endtask

    task automatic end_download();
        @(posedge clk_sys);
        ioctl_download_i <= 1'b0;
    endtask

    task automatic write_byte(logic [24:0] addr, logic [BYTE_W-1:0] data);
        @(posedge clk_sys);
        ioctl_wr_i   <= 1'b1;
        ioctl_addr_i <= addr;
        ioctl_dout_i <= data;
        @(posedge clk_sys);
        ioctl_wr_i   <= 1'b0;
    endtask

    task automatic readback();
        foreach (addr_q[k]) begin
            @(posedge clk_sys);
            rom_rd_addr_i <= addr_q[k];
            rd_exp        <= rom_model[addr_q[k]];
            rd_chk        <= 1'b1;
        end
        @(posedge clk_sys);
        rd_chk <= 1'b0;
    endtask

    // Reference for the reset causes and the density counter
    assign cause = !pll_locked_i || ioctl_download_i || status_i[ST_RESET] || mode_pulse;
    assign wr_bad = ioctl_wr_i && ioctl_download_i && (ioctl_index_i == DL_BINROM)
                 && load_rule(status_d) && ((ioctl_addr_i >> ROM_AW) != 0);

    always_ff @(posedge clk_sys or negedge arst_n_i) begin
        if (!arst_n_i) begin
            status_d   <= '0;
            mode_prev  <= '0;
            mode_pulse <= 1'b0;
            quiet_cnt  <= 0;
            ones_cnt   <= 0;
        end else begin
            status_d   <= status_i;
            mode_prev  <= status_d[MODE_BITS-1:0];
            mode_pulse <= (status_d[MODE_BITS-1:0] != mode_prev);
            quiet_cnt  <= cause ? 0 : (quiet_cnt < 255 ? quiet_cnt + 1 : quiet_cnt);
            if (cnt_clr) ones_cnt <= 0;
            else if (cnt_en) ones_cnt <= ones_cnt + int'(audio_o);
        end
    end

    a_ce_period: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        ce_10m7_o |=> !ce_10m7_o [*3] ##1 ce_10m7_o) else flag_mismatch("ce_10m7 period");
    a_ce_alive: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        !ce_10m7_o [*4] |=> ce_10m7_o) else flag_mismatch("ce_10m7 missing");
    a_ce5_period: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        ce_5m3_o |=> !ce_5m3_o [*7] ##1 ce_5m3_o) else flag_mismatch("ce_5m3 period");
    a_ce5_alive: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        !ce_5m3_o [*8] |=> ce_5m3_o) else flag_mismatch("ce_5m3 missing");
    a_ce_align: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        ce_5m3_o |-> ce_10m7_o) else flag_mismatch("ce_5m3 without ce_10m7");
    a_rst_fall: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        cause |-> ##[0:3] !core_rst_n_o) else flag_mismatch("core reset did not assert");
    a_rst_hold: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        !cause && quiet_cnt inside {[2:RST_HOLD-1]} |-> !core_rst_n_o)
        else flag_mismatch("core reset released early");
    a_rst_release: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        !cause && quiet_cnt >= RST_HOLD + 3 |-> core_rst_n_o)
        else flag_mismatch("core reset low without cause");
    a_decode: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        mem_ext_o == status_d[ST_MEM_LSB +: 3] && cart_o == status_d[ST_CART_LSB +: 2]
        && em64_opts_o == status_d[ST_EM64_LSB +: EM64_W] && border_o == status_d[ST_BORDER]
        && scanlines_o == status_d[ST_SCAN_LSB +: SCAN_W]
        && {cart_enable_o, kb64_enable_o} == cfg_flags(status_d))
        else flag_mismatch("configuration decode");
    a_joy: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        joy_a_o == (status_d[ST_JOY_SWAP] ? joy1_i : joy0_i)
        && joy_b_o == (status_d[ST_JOY_SWAP] ? joy0_i : joy1_i))
        else flag_mismatch("joystick routing");
    a_rd_data: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        rd_chk |=> rom_rd_data_o == $past(rd_exp)) else flag_mismatch("ROM readback data");
    a_loaded: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        $fell(ioctl_download_i) && expect_loaded |=> rom_loaded_o)
        else flag_mismatch("rom_loaded not set after load");
    a_not_loaded: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        $fell(ioctl_download_i) && !expect_loaded |=> !rom_loaded_o)
        else flag_mismatch("rom_loaded set without a written byte");
    a_dl_clear: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        $rose(ioctl_download_i) |=> !rom_loaded_o && !rom_overflow_o)
        else flag_mismatch("flags not cleared by new download");
    a_ovf_set: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        wr_bad |=> rom_overflow_o) else flag_mismatch("rom_overflow not set");
    a_ovf_only: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        $rose(rom_overflow_o) |-> $past(wr_bad)) else flag_mismatch("spurious rom_overflow");
    a_density: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
        dens_chk |-> ones_cnt <= dens_exp + 1 && ones_cnt + 1 >= dens_exp)
        else flag_mismatch("audio ones density");

    initial begin
        int m;
        int c;
        int i;
        logic [ROM_AW-1:0] a;
        logic [BYTE_W-1:0] d;
        logic [AUDIO_W-1:0] sample;
        arst_n_i         = 1'b0;
        pll_locked_i     = 1'b1;
        status_i         = '0;
        joy0_i           = '0;
        joy1_i           = '0;
        ioctl_download_i = 1'b0;
        ioctl_index_i    = '0;
        ioctl_wr_i       = 1'b0;
        ioctl_addr_i     = '0;
        ioctl_dout_i     = '0;
        rom_rd_addr_i    = '0;
        audio_i          = '0;
        tape_in_i        = 1'b0;
        {cnt_clr, cnt_en, dens_chk, rd_chk, expect_loaded} = '0;
        rd_exp   = '0;
        dens_exp = 0;
        repeat (16) @(posedge clk_sys);
        arst_n_i <= 1'b1;
        wait_release("power-up");
        repeat (40) @(posedge clk_sys);
        report_test("Test 1 clock enables");

        pll_locked_i <= 1'b0;
        repeat (10) @(posedge clk_sys);
        pll_locked_i <= 1'b1;
        wait_release("PLL lock loss");
        status_i[ST_RESET] <= 1'b1;
        repeat (10) @(posedge clk_sys);
        status_i[ST_RESET] <= 1'b0;
        wait_release("status reset bit");
        start_download(DL_BOOT);
        repeat (10) @(posedge clk_sys);
        end_download();
        wait_release("download");
        status_i[ST_MEM_LSB +: 3] <= MEM_EM5;
        wait_release("memory change");
        status_i[ST_MEM_LSB +: 3] <= MEM_NONE;
        wait_release("memory change back");
        status_i[ST_BORDER]        <= 1'b1;  // Outside the mode field
        status_i[ST_SCAN_LSB +: 2] <= 2'd2;
        status_i[ST_JOY_SWAP]      <= 1'b1;
        repeat (60) @(posedge clk_sys);
        status_i <= '0;
        repeat (60) @(posedge clk_sys);
        report_test("Test 2 reset causes");

        for (m = 0; m < 6; m++) begin
            for (c = 0; c < 4; c++) begin
                @(posedge clk_sys);
                status_i[ST_MEM_LSB +: 3]  <= 3'(m);
                status_i[ST_CART_LSB +: 2] <= 2'(c);
                status_i[ST_JOY_SWAP]      <= c[0];
                status_i[ST_BORDER]        <= c[1];
                status_i[ST_SCAN_LSB +: 2] <= 2'(m);
                status_i[ST_EM64_LSB +: 4] <= 4'($random(seed));
                joy0_i                     <= JOY_W'($random(seed));
                joy1_i                     <= JOY_W'($random(seed));
                repeat (2) @(posedge clk_sys);
            end
        end
        status_i <= '0;
        wait_release("configuration sweep");
        report_test("Test 3 configuration decode");

        start_download(DL_BINROM);
        for (i = 0; i < 24; i++) begin
            a = ROM_AW'($random(seed));
            d = BYTE_W'($random(seed));
            write_byte(25'(a), d);
            rom_model[a] = d;
            addr_q.push_back(a);
        end
        expect_loaded <= 1'b1;
        end_download();
        wait_loaded();
        readback();
        report_test("Test 4 ROM load");

        expect_loaded <= 1'b0;
        start_download(DL_BINROM);
        write_byte(25'(2**ROM_AW + addr_q[0]), ~rom_model[addr_q[0]]);
        repeat (2) @(posedge clk_sys);
        end_download();
        start_download(DL_BOOT);  // Also clears the overflow flag
        write_byte(25'(addr_q[1]), ~rom_model[addr_q[1]]);
        end_download();
        @(posedge clk_sys);
        status_i[ST_CART_LSB +: 2] <= CART_BASIC_I;
        start_download(DL_BINROM);
        write_byte(25'(addr_q[2]), ~rom_model[addr_q[2]]);
        end_download();
        @(posedge clk_sys);
        status_i <= '0;
        readback();
        wait_release("dropped writes");
        report_test("Test 5 dropped writes");

        for (i = 0; i < 3; i++) begin
            sample = AUDIO_W'($random(seed));
            @(posedge clk_sys);
            status_i[ST_TAPE_OFF] <= (i == 0);
            tape_in_i             <= (i == 1);
            audio_i               <= sample;
            dens_exp              <= mixed_sample(int'(sample), i != 0, i == 1);
            repeat (4) @(posedge clk_sys);
            cnt_clr <= 1'b1;
            @(posedge clk_sys);
            cnt_clr <= 1'b0;
            cnt_en  <= 1'b1;
            repeat (2**AUDIO_W) @(posedge clk_sys);
            cnt_en   <= 1'b0;
            dens_chk <= 1'b1;
            @(posedge clk_sys);
            dens_chk <= 1'b0;
        end
        report_test("Test 6 audio density");

        repeat (4) @(posedge clk_sys);
        $display("Tests run: 6, errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
